/* common/uart_pkg.sv */
`default_nettype none

package uart_pkg;

	localparam int DATA_BITS = 8; // payload bits per frame
	localparam int SYNC_STAGES = 3; // flops in the rx line synchronizer
	localparam int FRAME_BITS = DATA_BITS + 2; // start + data + stop, parity adds one

	localparam logic START_BIT = 1'b0; // start bit level
	localparam logic STOP_BIT = 1'b1; // stop bit level
	localparam logic LINE_IDLE = 1'b1; // line rests high between frames

	typedef struct packed {
		logic parity_en; // append a parity bit
		logic parity_odd; // 1 = odd parity, 0 = even
		logic loopback; // rx listens to our own tx line
	} uart_cfg_t;

	typedef struct packed {
		logic [DATA_BITS-1:0] data; // received byte
		logic parity_error; // parity bit did not match
		logic frame_error; // stop bit sampled low
		logic parity_bit; // parity bit as seen on the line, 0 with parity off
	} uart_rx_result_t;

	// no parity, even, external line
	localparam uart_cfg_t CFG_DEFAULT = '{
		parity_en: 1'b0,
		parity_odd: 1'b0,
		loopback: 1'b0
	};

endpackage

`default_nettype wire

/* design/uart_config.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_config (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_cfg_write,
	input wire uart_pkg::uart_cfg_t i_cfg,
	output uart_pkg::uart_cfg_t o_cfg
);

	// settings steer tx framing, rx checking and the line select in the top
	always_ff @(posedge clk) begin
		if (reset)
			o_cfg <= uart_pkg::CFG_DEFAULT; // no parity, even, external line
		else if (i_cfg_write)
			o_cfg <= i_cfg; // in effect the cycle after the strobe
	end

endmodule

`default_nettype wire

/* design/uart_baud_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen #(
	parameter int CLOCKS_PER_BIT = 8
) (
	input wire logic clk,
	input wire logic reset,
	output logic o_bit_tick
);

	localparam int CNT_W = $clog2(CLOCKS_PER_BIT);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLOCKS_PER_BIT - 1);

	logic [CNT_W-1:0] div_cnt; // free running divider

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
			o_bit_tick <= 1'b0;
		end else begin
			o_bit_tick <= (div_cnt == LAST_CNT); // one cycle pulse per bit period
			if (div_cnt == LAST_CNT)
				div_cnt <= '0; // wrap, non power of two rates work too
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* uart_tx/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_enable,
	input wire logic [uart_pkg::DATA_BITS-1:0] i_data,
	input wire uart_pkg::uart_cfg_t i_cfg,
	input wire logic i_bit_tick,
	output logic o_serial_out,
	output logic o_busy
);

	localparam int SR_W = uart_pkg::FRAME_BITS + 1; // room for the parity bit
	localparam int CNT_W = $clog2(SR_W + 1);
	localparam logic [CNT_W-1:0] LEN_PLAIN = CNT_W'(uart_pkg::FRAME_BITS);
	localparam logic [CNT_W-1:0] LEN_PARITY = CNT_W'(uart_pkg::FRAME_BITS + 1);

	logic [SR_W-1:0] frame_sr; // lsb goes out first
	logic [CNT_W-1:0] bit_cnt; // bits already put on the line
	logic [CNT_W-1:0] frame_len; // 10 or 11 bits, fixed at enable
	logic waiting; // busy but first tick not seen yet
	logic parity_bit;
	logic start_frame;

	assign parity_bit = (^i_data) ^ i_cfg.parity_odd; // even parity unless odd selected
	assign start_frame = i_enable && !o_busy; // enable while busy is dropped

	// frame payload, shifted once per bit period
	always_ff @(posedge clk) begin
		if (start_frame) begin
			if (i_cfg.parity_en)
				frame_sr <= {uart_pkg::STOP_BIT, parity_bit, i_data, uart_pkg::START_BIT};
			else
				frame_sr <= {uart_pkg::LINE_IDLE, uart_pkg::STOP_BIT, i_data,
					uart_pkg::START_BIT}; // stop bit right after the data
			frame_len <= i_cfg.parity_en ? LEN_PARITY : LEN_PLAIN;
		end else if (o_busy && i_bit_tick) begin
			frame_sr <= {uart_pkg::LINE_IDLE, frame_sr[SR_W-1:1]}; // fill with idle level
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_busy <= 1'b0;
			waiting <= 1'b0;
			bit_cnt <= '0;
			o_serial_out <= uart_pkg::LINE_IDLE;
		end else if (start_frame) begin
			o_busy <= 1'b1; // visible the cycle after enable
			waiting <= 1'b1; // line stays idle until the next tick
		end else if (o_busy && i_bit_tick) begin
			if (waiting) begin
				waiting <= 1'b0;
				o_serial_out <= frame_sr[0]; // start bit
				bit_cnt <= CNT_W'(1);
			end else if (bit_cnt == frame_len) begin
				// stop bit has had its full period
				o_busy <= 1'b0;
				o_serial_out <= uart_pkg::LINE_IDLE;
			end else begin
				o_serial_out <= frame_sr[0]; // next data, parity or stop bit
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* uart_rx/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
	parameter int CLOCKS_PER_BIT = 8
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_serial_in,
	input wire uart_pkg::uart_cfg_t i_cfg,
	output logic o_rx_valid,
	output uart_pkg::uart_rx_result_t o_rx_result
);

	localparam int PHASE_W = $clog2(CLOCKS_PER_BIT);
	localparam int IDX_W = $clog2(uart_pkg::DATA_BITS);
	localparam logic [PHASE_W-1:0] LAST_PHASE = PHASE_W'(CLOCKS_PER_BIT - 1);
	localparam logic [PHASE_W-1:0] HALF_PHASE = PHASE_W'(CLOCKS_PER_BIT / 2 - 1);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(uart_pkg::DATA_BITS - 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_PARITY,
		ST_STOP
	} state_t;

	state_t state;
	logic [uart_pkg::SYNC_STAGES-1:0] sync_ff; // line enters at bit 0
	logic rx_line; // synchronized line
	logic line_prev; // for falling edge detect
	logic [PHASE_W-1:0] phase; // clocks since last sample point
	logic [IDX_W-1:0] bit_idx; // data bit being received
	logic [uart_pkg::DATA_BITS-1:0] data_sr; // filled from the top, lsb first on line
	logic rx_par; // sampled parity bit
	logic phase_done;
	logic start_edge;
	logic parity_bad;

	assign rx_line = sync_ff[uart_pkg::SYNC_STAGES-1];
	assign phase_done = (phase == LAST_PHASE);
	assign start_edge = line_prev && !rx_line;
	// expected parity follows the same rule as the transmitter
	assign parity_bad = i_cfg.parity_en && (rx_par != ((^data_sr) ^ i_cfg.parity_odd));

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_ff <= '1; // idle high, no false start out of reset
			line_prev <= uart_pkg::LINE_IDLE;
		end else begin
			sync_ff <= {sync_ff[uart_pkg::SYNC_STAGES-2:0], i_serial_in};
			line_prev <= rx_line;
		end
	end

	// sampled payload
	always_ff @(posedge clk) begin
		if (state == ST_START)
			rx_par <= 1'b0; // stays 0 when no parity bit follows
		else if (state == ST_DATA && phase_done)
			data_sr <= {rx_line, data_sr[uart_pkg::DATA_BITS-1:1]};
		else if (state == ST_PARITY && phase_done)
			rx_par <= rx_line;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			phase <= '0;
			bit_idx <= '0;
			o_rx_valid <= 1'b0;
			o_rx_result <= '0;
		end else begin
			o_rx_valid <= 1'b0; // single cycle pulse
			case (state)
				ST_IDLE: begin
					phase <= '0;
					if (start_edge)
						state <= ST_START;
				end
				ST_START: begin
					if (phase == HALF_PHASE) begin
						phase <= '0;
						bit_idx <= '0;
						// a line back high at mid start bit was a glitch
						state <= (rx_line == uart_pkg::START_BIT) ? ST_DATA : ST_IDLE;
					end else begin
						phase <= phase + 1'b1;
					end
				end
				ST_DATA: begin
					phase <= phase_done ? '0 : phase + 1'b1;
					if (phase_done) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == LAST_IDX)
							state <= i_cfg.parity_en ? ST_PARITY : ST_STOP;
					end
				end
				ST_PARITY: begin
					phase <= phase_done ? '0 : phase + 1'b1;
					if (phase_done)
						state <= ST_STOP;
				end
				ST_STOP: begin
					phase <= phase_done ? '0 : phase + 1'b1;
					if (phase_done) begin
						// report at mid stop bit, no wait for its end
						o_rx_valid <= 1'b1;
						o_rx_result.data <= data_sr;
						o_rx_result.parity_error <= parity_bad;
						o_rx_result.frame_error <= (rx_line != uart_pkg::STOP_BIT);
						o_rx_result.parity_bit <= rx_par;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
	parameter int CLOCKS_PER_BIT = 8
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_enable,
	input wire logic [uart_pkg::DATA_BITS-1:0] i_data,
	input wire logic i_serial_in,
	input wire logic i_cfg_write,
	input wire uart_pkg::uart_cfg_t i_cfg,
	output logic o_serial_out,
	output logic o_busy,
	output logic o_rx_valid,
	output uart_pkg::uart_rx_result_t o_rx_result,
	output uart_pkg::uart_cfg_t o_cfg
);

	uart_pkg::uart_cfg_t cfg; // registered settings
	logic bit_tick; // tx bit period strobe
	logic rx_line; // line the receiver listens to

	// loopback feeds the receiver from our own tx output
	assign rx_line = cfg.loopback ? o_serial_out : i_serial_in;
	assign o_cfg = cfg;

	uart_config u_config (
		.clk (clk),
		.reset (reset),
		.i_cfg_write (i_cfg_write),
		.i_cfg (i_cfg),
		.o_cfg (cfg)
	);

	uart_baud_gen #(
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT)
	) u_baud_gen (
		.clk (clk),
		.reset (reset),
		.o_bit_tick (bit_tick)
	);

	uart_tx u_tx (
		.clk (clk),
		.reset (reset),
		.i_enable (i_enable),
		.i_data (i_data),
		.i_cfg (cfg),
		.i_bit_tick (bit_tick),
		.o_serial_out (o_serial_out),
		.o_busy (o_busy)
	);

	// rx keeps its own phase, it does not use the tx tick
	uart_rx #(
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT)
	) u_rx (
		.clk (clk),
		.reset (reset),
		.i_serial_in (rx_line),
		.i_cfg (cfg),
		.o_rx_valid (o_rx_valid),
		.o_rx_result (o_rx_result)
	);

endmodule

`default_nettype wire

/* tests/uart_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_checker (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_enable,
	input wire logic i_busy,
	input wire logic i_serial_out,
	input wire logic i_rx_valid
);

	int assert_failures = 0; // polled by the testbench

	// tx line rests high whenever no frame is in flight
	a_line_idle: assert property (@(posedge clk) disable iff (reset)
		!i_busy |-> i_serial_out)
		else begin
			assert_failures++;
			$error("tx line low while the transmitter is not busy");
		end

	// receive result is a single cycle strobe
	a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
		i_rx_valid |=> !i_rx_valid)
		else begin
			assert_failures++;
			$error("rx valid held high for two cycles");
		end

	// an accepted enable raises busy on the next clock
	a_busy_after_enable: assert property (@(posedge clk) disable iff (reset)
		(i_enable && !i_busy) |=> i_busy)
		else begin
			assert_failures++;
			$error("busy did not rise the cycle after an enable while idle");
		end

endmodule

`default_nettype wire

/* tests/uart_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

	localparam int CPB = 8; // clocks per bit for the DUT
	localparam time CLK_PERIOD = 100;
	localparam time DRIVE_DELAY = 10; // inputs change this long after the rising edge
	localparam int RESET_CYCLES = 16;
	localparam int DB = uart_pkg::DATA_BITS;
	localparam int FRAME_MAX = DB + 3; // start, data, parity, stop
	localparam int NUM_FRAMES = 20 * 3 + 30 * 3 + 8 * 2 + 3; // glitch window counts as one
	localparam int WATCHDOG_CYCLES = NUM_FRAMES * 12 * CPB + NUM_FRAMES * 2 * CPB + 100 * CPB;
	localparam int RX_WAIT_CYCLES = 13 * CPB + uart_pkg::SYNC_STAGES + 4;

	logic clk;
	logic reset;
	logic i_enable;
	logic [DB-1:0] i_data;
	logic i_serial_in;
	logic i_cfg_write;
	uart_pkg::uart_cfg_t i_cfg;
	logic o_serial_out;
	logic o_busy;
	logic o_rx_valid;
	uart_pkg::uart_rx_result_t o_rx_result;
	uart_pkg::uart_cfg_t o_cfg;

	logic [15:0] lfsr_state; // random byte source

	uart_top #(
		.CLOCKS_PER_BIT (CPB)
	) UUT (
		.clk (clk),
		.reset (reset),
		.i_enable (i_enable),
		.i_data (i_data),
		.i_serial_in (i_serial_in),
		.i_cfg_write (i_cfg_write),
		.i_cfg (i_cfg),
		.o_serial_out (o_serial_out),
		.o_busy (o_busy),
		.o_rx_valid (o_rx_valid),
		.o_rx_result (o_rx_result),
		.o_cfg (o_cfg)
	);

	bind uart_top uart_checker u_checker (
		.clk (clk),
		.reset (reset),
		.i_enable (i_enable),
		.i_busy (o_busy),
		.i_serial_out (o_serial_out),
		.i_rx_valid (o_rx_valid)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("Test FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			fail_run($sformatf("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_cfg(input uart_pkg::uart_cfg_t got, input uart_pkg::uart_cfg_t exp,
		input string what);
		if (got !== exp)
			fail_run($sformatf("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_result(input uart_pkg::uart_rx_result_t got,
		input uart_pkg::uart_rx_result_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf({"FAIL at %0t: %s data=%h perr=%b ferr=%b pbit=%b,",
				" expected data=%h perr=%b ferr=%b pbit=%b"}, $time, what,
				got.data, got.parity_error, got.frame_error, got.parity_bit,
				exp.data, exp.parity_error, exp.frame_error, exp.parity_bit));
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_byte(output logic [DB-1:0] b);
		for (int i = 0; i < DB; i++) begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit
			b[i] = lfsr_state[0];
		end
	endtask

	function automatic logic parity_of(input logic [DB-1:0] b, input logic odd);
		int ones;
		ones = 0;
		for (int i = 0; i < DB; i++)
			ones += b[i];
		return (ones % 2 == 1) ^ odd; // even parity brings the ones count to even
	endfunction

	function automatic logic [FRAME_MAX-1:0] expected_frame(input logic [DB-1:0] b,
		input logic en, input logic odd);
		logic [FRAME_MAX-1:0] f;
		f = '1;
		f[0] = 1'b0; // start
		f[1 +: DB] = b; // lsb first
		if (en)
			f[DB+1] = parity_of(b, odd); // stop stays in the top slot
		return f;
	endfunction

	function automatic uart_pkg::uart_cfg_t make_cfg(input logic en, input logic odd,
		input logic lb);
		uart_pkg::uart_cfg_t c;
		c.parity_en = en;
		c.parity_odd = odd;
		c.loopback = lb;
		return c;
	endfunction

	function automatic uart_pkg::uart_rx_result_t make_result(input logic [DB-1:0] b,
		input logic perr, input logic ferr, input logic pbit);
		uart_pkg::uart_rx_result_t r;
		r.data = b;
		r.parity_error = perr;
		r.frame_error = ferr;
		r.parity_bit = pbit;
		return r;
	endfunction

	task automatic write_cfg(input uart_pkg::uart_cfg_t cfg);
		@(posedge clk);
		#DRIVE_DELAY;
		i_cfg = cfg;
		i_cfg_write = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		i_cfg_write = 1'b0;
		check_cfg(o_cfg, cfg, "config after write"); // takes effect one cycle after strobe
	endtask

	task automatic send_byte(input logic [DB-1:0] b);
		@(posedge clk);
		#DRIVE_DELAY;
		i_data = b;
		i_enable = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		i_enable = 1'b0;
	endtask

	// second enable mid frame with other data, must be ignored
	task automatic pulse_enable_busy(input logic [DB-1:0] other, input logic [DB-1:0] held);
		repeat (4 * CPB) @(posedge clk);
		#DRIVE_DELAY;
		check_bit(o_busy, 1'b1, "busy before the extra enable");
		i_data = other;
		i_enable = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		i_enable = 1'b0;
		i_data = held;
	endtask

	task automatic wait_tx_idle();
		int n;
		n = 0;
		while (o_busy) begin
			@(negedge clk);
			n++;
			if (n > 12 * CPB)
				fail_run("the transmitter stayed busy longer than one frame");
		end
	endtask

	task automatic wait_rx_valid(output uart_pkg::uart_rx_result_t res);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > RX_WAIT_CYCLES)
				fail_run("no rx valid pulse arrived within one frame time");
		end while (o_rx_valid !== 1'b1);
		res = o_rx_result;
	endtask

	// sends start, data, optional parity and the given stop level on the input pin
	task automatic drive_line_frame(input logic [DB-1:0] b, input logic with_parity,
		input logic par, input logic stop);
		logic [FRAME_MAX-1:0] bits;
		int n;
		bits = '1;
		bits[0] = 1'b0;
		bits[1 +: DB] = b;
		bits[DB+1] = with_parity ? par : stop;
		bits[DB+2] = stop;
		n = with_parity ? DB + 3 : DB + 2;
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			i_serial_in = bits[i];
			repeat (CPB - 1) @(posedge clk); // CPB clocks per bit
		end
		@(posedge clk);
		#DRIVE_DELAY;
		i_serial_in = 1'b1; // back to idle
	endtask

	task automatic drive_glitch(input int cycles);
		@(posedge clk);
		#DRIVE_DELAY;
		i_serial_in = 1'b0;
		repeat (cycles) @(posedge clk);
		#DRIVE_DELAY;
		i_serial_in = 1'b1;
	endtask

	// samples every clock of every bit, keeps the mid bit value
	task automatic capture_tx_frame(input int nbits, output logic [FRAME_MAX-1:0] bits);
		int n;
		logic first;
		logic level;
		n = 0;
		bits = '1;
		do begin
			@(negedge clk);
			n++;
			if (n > 2 * CPB)
				fail_run("no start bit on the tx line after an enable");
		end while (o_serial_out !== 1'b0);
		for (int k = 0; k < nbits * CPB; k++) begin
			if (k > 0)
				@(negedge clk);
			level = o_serial_out;
			if (k % CPB == 0)
				first = level;
			else
				check_bit(level, first, "tx line within one bit period");
			if (k % CPB == CPB / 2)
				bits[k / CPB] = level;
			check_bit(o_busy, 1'b1, "busy during the frame");
		end
		@(negedge clk);
		check_bit(o_busy, 1'b0, "busy right after the stop bit");
		check_bit(o_serial_out, 1'b1, "tx line after the frame");
	endtask

	task automatic test_reset_state();
		@(negedge clk);
		check_bit(o_busy, 1'b0, "busy after reset");
		check_bit(o_rx_valid, 1'b0, "rx valid after reset");
		check_bit(o_serial_out, 1'b1, "tx line after reset");
		check_bit(o_rx_result.parity_error, 1'b0, "parity error after reset");
		check_bit(o_rx_result.frame_error, 1'b0, "frame error after reset");
		check_cfg(o_cfg, make_cfg(1'b0, 1'b0, 1'b0), "config after reset");
		write_cfg(make_cfg(1'b1, 1'b1, 1'b1));
		write_cfg(make_cfg(1'b1, 1'b0, 1'b0));
		write_cfg(make_cfg(1'b0, 1'b0, 1'b0));
	endtask

	task automatic test_tx_format();
		logic [DB-1:0] b;
		logic [FRAME_MAX-1:0] seen;
		logic [FRAME_MAX-1:0] exp;
		logic en;
		logic odd;
		int nbits;
		for (int mode = 0; mode < 3; mode++) begin
			en = (mode != 0); // none, even, odd
			odd = (mode == 2);
			write_cfg(make_cfg(en, odd, 1'b0));
			nbits = en ? DB + 3 : DB + 2;
			for (int k = 0; k < 20; k++) begin
				random_byte(b);
				exp = expected_frame(b, en, odd);
				send_byte(b);
				fork
					capture_tx_frame(nbits, seen);
					pulse_enable_busy(~b, b);
				join
				for (int i = 0; i < nbits; i++)
					check_bit(seen[i], exp[i], $sformatf("tx bit %0d of byte %h", i, b));
			end
		end
	endtask

	task automatic test_loopback();
		logic [DB-1:0] b;
		uart_pkg::uart_rx_result_t got;
		logic en;
		logic odd;
		for (int mode = 0; mode < 3; mode++) begin
			en = (mode != 0);
			odd = (mode == 2);
			write_cfg(make_cfg(en, odd, 1'b1));
			for (int k = 0; k < 30; k++) begin
				random_byte(b);
				send_byte(b);
				wait_rx_valid(got);
				check_result(got, make_result(b, 1'b0, 1'b0, en ? parity_of(b, odd) : 1'b0),
					"loopback result");
				wait_tx_idle();
			end
		end
		write_cfg(make_cfg(1'b0, 1'b0, 1'b0));
	endtask

	task automatic test_parity_error();
		logic [DB-1:0] b;
		uart_pkg::uart_rx_result_t got;
		logic inv;
		logic par;
		write_cfg(make_cfg(1'b1, 1'b0, 1'b0)); // external line, even parity
		for (int k = 0; k < 16; k++) begin
			inv = (k >= 8); // second half carries a wrong parity bit
			random_byte(b);
			par = parity_of(b, 1'b0) ^ inv;
			fork
				drive_line_frame(b, 1'b1, par, 1'b1);
				wait_rx_valid(got);
			join
			check_result(got, make_result(b, inv, 1'b0, par), "external parity result");
			repeat (2 * CPB) @(posedge clk);
		end
	endtask

	task automatic test_framing();
		logic [DB-1:0] b;
		uart_pkg::uart_rx_result_t got;
		uart_pkg::uart_rx_result_t exp_res;
		random_byte(b);
		exp_res = make_result(b, 1'b0, 1'b1, parity_of(b, 1'b0));
		fork
			drive_line_frame(b, 1'b1, parity_of(b, 1'b0), 1'b0); // low stop bit
			wait_rx_valid(got);
		join
		check_result(got, exp_res, "low stop bit");
		repeat (2 * CPB) @(posedge clk);
		drive_glitch(CPB / 2 - 1); // shorter than half a bit
		repeat (12 * CPB) begin
			@(negedge clk);
			check_bit(o_rx_valid, 1'b0, "rx valid after a short glitch");
		end
		check_result(o_rx_result, exp_res, "result held after a glitch");
		random_byte(b);
		fork
			drive_line_frame(b, 1'b1, parity_of(b, 1'b0), 1'b1);
			wait_rx_valid(got);
		join
		check_result(got, make_result(b, 1'b0, 1'b0, parity_of(b, 1'b0)), "frame after glitch");
	endtask

	initial begin
		wait (UUT.u_checker.assert_failures != 0);
		fail_run("a protocol assertion in the bound checker failed");
	end

	initial begin
		repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
		fail_run("watchdog timeout, the tests did not finish in time");
	end

	initial begin
		lfsr_state = 16'd44918;
		reset = 1'b1;
		i_enable = 1'b0;
		i_data = '0;
		i_serial_in = 1'b1; // idle line
		i_cfg_write = 1'b0;
		i_cfg = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		test_reset_state();
		test_tx_format();
		test_loopback();
		test_parity_error();
		test_framing();
		repeat (4) @(posedge clk);
		if (UUT.u_checker.assert_failures == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
common/uart_pkg.sv
design/uart_config.sv
design/uart_baud_gen.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx.sv
design/uart_top.sv
tests/uart_checker.sv
tests/uart_tb.sv
